//--- design/huff_pkg.sv
`default_nettype none

package huff_pkg;

    localparam int NUM_SYMBOLS_DEF = 128;
    localparam int COUNT_W_DEF     = 32;
    localparam int FIFO_DEPTH_DEF  = 4;

    // Marks an empty best slot, cut down to the count width where used
    localparam logic [63:0] EMPTY_COUNT = '1;

    // Top index bit is the node flag
    function automatic int index_w(input int num_symbols);
        return $clog2(2 * num_symbols);
    endfunction

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_WAIT_CREDIT
    } scan_state_t;

    typedef enum logic [1:0] {
        FIND_IDLE,
        FIND_COLLECT,
        FIND_REPORT
    } find_state_t;

endpackage

`default_nettype wire

//--- design/freq_table_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module freq_table_scanner #(
    parameter int NUM_SYMBOLS = huff_pkg::NUM_SYMBOLS_DEF,
    parameter int COUNT_W     = huff_pkg::COUNT_W_DEF,
    parameter int FIFO_DEPTH  = huff_pkg::FIFO_DEPTH_DEF
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      start,
    input  logic                                      wr_en,
    input  logic [huff_pkg::index_w(NUM_SYMBOLS)-1:0] wr_addr,
    input  logic [COUNT_W-1:0]                        wr_count,
    input  logic                                      credit_return,
    output logic                                      ent_valid,
    output logic [huff_pkg::index_w(NUM_SYMBOLS)-1:0] ent_index,
    output logic [COUNT_W-1:0]                        ent_count,
    output logic                                      ent_last,
    output logic                                      scan_active
);
    import huff_pkg::*;

    localparam int IDX_W    = index_w(NUM_SYMBOLS);
    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(2 * NUM_SYMBOLS - 1);

    logic [COUNT_W-1:0]  table_mem [2*NUM_SYMBOLS];  // Leaves then internal nodes
    logic [IDX_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] credit_cnt;
    logic [CREDIT_W-1:0] credit_avail;
    logic                send;
    scan_state_t         scan_state;

    assign scan_active  = (scan_state != SCAN_IDLE);
    assign credit_avail = credit_cnt - CREDIT_W'(ent_valid);  // Entry on ent_* still owns one
    assign send         = scan_active && (credit_avail != '0);

    always_ff @(posedge clk) begin
        if (wr_en && !scan_active) begin  // Table frozen during a scan
            table_mem[wr_addr] <= wr_count;
        end
    end

    // Registered table read, one entry per send
    always_ff @(posedge clk) begin
        if (send) begin
            ent_index <= rd_ptr;
            ent_count <= table_mem[rd_ptr];
            ent_last  <= (rd_ptr == LAST_IDX);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_state <= SCAN_IDLE;
            rd_ptr     <= '0;
            ent_valid  <= 1'b0;
            credit_cnt <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            ent_valid  <= send;
            credit_cnt <= credit_cnt - CREDIT_W'(ent_valid) + CREDIT_W'(credit_return);
            case (scan_state)
                SCAN_IDLE: begin
                    if (start) begin
                        rd_ptr     <= '0;
                        scan_state <= SCAN_RUN;
                    end
                end
                SCAN_RUN, SCAN_WAIT_CREDIT: begin
                    if (send) begin
                        rd_ptr     <= rd_ptr + 1'b1;
                        scan_state <= (rd_ptr == LAST_IDX) ? SCAN_IDLE : SCAN_RUN;
                    end else begin
                        scan_state <= SCAN_WAIT_CREDIT;  // rd_ptr keeps its place
                    end
                end
                default: scan_state <= SCAN_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/entry_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module entry_fifo #(
    parameter int FIFO_DEPTH  = huff_pkg::FIFO_DEPTH_DEF,
    parameter int NUM_SYMBOLS = huff_pkg::NUM_SYMBOLS_DEF,
    parameter int COUNT_W     = huff_pkg::COUNT_W_DEF
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      ent_valid,
    input  logic [huff_pkg::index_w(NUM_SYMBOLS)-1:0] ent_index,
    input  logic [COUNT_W-1:0]                        ent_count,
    input  logic                                      ent_last,
    input  logic                                      buf_pop,
    output logic                                      buf_valid,
    output logic [huff_pkg::index_w(NUM_SYMBOLS)-1:0] buf_index,
    output logic [COUNT_W-1:0]                        buf_count,
    output logic                                      buf_last,
    output logic                                      credit_return
);
    import huff_pkg::*;

    localparam int IDX_W = index_w(NUM_SYMBOLS);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int OCC_W = $clog2(FIFO_DEPTH + 1);

    logic [IDX_W-1:0]   idx_mem  [FIFO_DEPTH];
    logic [COUNT_W-1:0] cnt_mem  [FIFO_DEPTH];
    logic               last_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [OCC_W-1:0]   occupancy;
    logic               pop;

    // Wraps for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign buf_valid     = (occupancy != '0);
    assign pop           = buf_pop && buf_valid;
    assign credit_return = pop;  // Slot freed this cycle
    assign buf_index     = idx_mem[rd_ptr];
    assign buf_count     = cnt_mem[rd_ptr];
    assign buf_last      = last_mem[rd_ptr];

    // No full check, the scanner never sends without a credit
    always_ff @(posedge clk) begin
        if (ent_valid) begin
            idx_mem[wr_ptr]  <= ent_index;
            cnt_mem[wr_ptr]  <= ent_count;
            last_mem[wr_ptr] <= ent_last;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (ent_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            occupancy <= occupancy + OCC_W'(ent_valid) - OCC_W'(pop);
        end
    end

endmodule

`default_nettype wire

//--- design/least_pair_finder.sv
`timescale 1ns/100ps
`default_nettype none

module least_pair_finder #(
    parameter int NUM_SYMBOLS = huff_pkg::NUM_SYMBOLS_DEF,
    parameter int COUNT_W     = huff_pkg::COUNT_W_DEF
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      hold,
    input  logic                                      buf_valid,
    input  logic [huff_pkg::index_w(NUM_SYMBOLS)-1:0] buf_index,
    input  logic [COUNT_W-1:0]                        buf_count,
    input  logic                                      buf_last,
    input  logic                                      result_ack,
    input  logic                                      scan_active,
    output logic                                      buf_pop,
    output logic                                      busy,
    output logic                                      result_valid,
    output logic                                      pair_found,
    output logic [huff_pkg::index_w(NUM_SYMBOLS)-1:0] least1,
    output logic [huff_pkg::index_w(NUM_SYMBOLS)-1:0] least2,
    output logic [COUNT_W-1:0]                        pair_sum
);
    import huff_pkg::*;

    localparam int IDX_W = index_w(NUM_SYMBOLS);
    localparam logic [COUNT_W-1:0] SENTINEL = EMPTY_COUNT[COUNT_W-1:0];

    find_state_t        find_state;
    logic [COUNT_W-1:0] best1_val;
    logic [COUNT_W-1:0] best2_val;
    logic [IDX_W-1:0]   best1_idx;
    logic [IDX_W-1:0]   best2_idx;
    logic [COUNT_W-1:0] nxt1_val;
    logic [COUNT_W-1:0] nxt2_val;
    logic [IDX_W-1:0]   nxt1_idx;
    logic [IDX_W-1:0]   nxt2_idx;
    logic               found;
    logic               last_pop;

    assign buf_pop  = (find_state == FIND_COLLECT) && buf_valid && !hold;
    assign busy     = scan_active || (find_state != FIND_IDLE);
    assign last_pop = buf_pop && buf_last;

    // Strict compares, so on a tie the earlier index stays ahead
    always_comb begin
        nxt1_val = best1_val;
        nxt1_idx = best1_idx;
        nxt2_val = best2_val;
        nxt2_idx = best2_idx;
        if (buf_count != '0) begin
            if (buf_count < best1_val) begin
                nxt2_val = best1_val;
                nxt2_idx = best1_idx;
                nxt1_val = buf_count;
                nxt1_idx = buf_index;
            end else if (buf_count < best2_val) begin
                nxt2_val = buf_count;
                nxt2_idx = buf_index;
            end
        end
    end

    assign found = (nxt2_val != SENTINEL);  // Second slot filled means two nonzero seen

    always_ff @(posedge clk) begin
        if (find_state == FIND_IDLE) begin
            best1_val <= SENTINEL;  // Fresh start for the next scan
            best2_val <= SENTINEL;
            best1_idx <= '0;
            best2_idx <= '0;
        end else if (buf_pop) begin
            best1_val <= nxt1_val;
            best2_val <= nxt2_val;
            best1_idx <= nxt1_idx;
            best2_idx <= nxt2_idx;
        end
    end

    // Result captured once, with the last entry folded in
    always_ff @(posedge clk) begin
        if (last_pop) begin
            pair_found <= found;
            least1     <= found ? nxt1_idx : '0;
            least2     <= found ? nxt2_idx : '0;
            pair_sum   <= found ? nxt1_val + nxt2_val : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            find_state   <= FIND_IDLE;
            result_valid <= 1'b0;
        end else begin
            case (find_state)
                FIND_IDLE: begin
                    if (scan_active) begin
                        find_state <= FIND_COLLECT;
                    end
                end
                FIND_COLLECT: begin
                    if (last_pop) begin
                        find_state   <= FIND_REPORT;
                        result_valid <= 1'b1;
                    end
                end
                FIND_REPORT: begin
                    if (result_ack) begin
                        find_state   <= FIND_IDLE;
                        result_valid <= 1'b0;
                    end
                end
                default: find_state <= FIND_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/huff_min_search.sv
`timescale 1ns/100ps
`default_nettype none

module huff_min_search #(
    parameter int NUM_SYMBOLS = huff_pkg::NUM_SYMBOLS_DEF,
    parameter int COUNT_W     = huff_pkg::COUNT_W_DEF,
    parameter int FIFO_DEPTH  = huff_pkg::FIFO_DEPTH_DEF
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      start,
    input  logic                                      wr_en,
    input  logic [huff_pkg::index_w(NUM_SYMBOLS)-1:0] wr_addr,
    input  logic [COUNT_W-1:0]                        wr_count,
    input  logic                                      hold,
    input  logic                                      result_ack,
    output logic                                      busy,
    output logic                                      result_valid,
    output logic                                      pair_found,
    output logic [huff_pkg::index_w(NUM_SYMBOLS)-1:0] least1,
    output logic [huff_pkg::index_w(NUM_SYMBOLS)-1:0] least2,
    output logic [COUNT_W-1:0]                        pair_sum
);
    import huff_pkg::*;

    localparam int IDX_W = index_w(NUM_SYMBOLS);

    logic               ent_valid;
    logic [IDX_W-1:0]   ent_index;
    logic [COUNT_W-1:0] ent_count;
    logic               ent_last;
    logic               credit_return;
    logic               buf_valid;
    logic [IDX_W-1:0]   buf_index;
    logic [COUNT_W-1:0] buf_count;
    logic               buf_last;
    logic               buf_pop;
    logic               scan_active;

    freq_table_scanner #(
        .NUM_SYMBOLS(NUM_SYMBOLS),
        .COUNT_W    (COUNT_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_scanner (
        .clk          (clk),
        .rst          (rst),
        .start        (start && !busy),  // Start ignored until the result is acknowledged
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_count     (wr_count),
        .credit_return(credit_return),
        .ent_valid    (ent_valid),
        .ent_index    (ent_index),
        .ent_count    (ent_count),
        .ent_last     (ent_last),
        .scan_active  (scan_active)
    );

    entry_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .NUM_SYMBOLS(NUM_SYMBOLS),
        .COUNT_W    (COUNT_W)
    ) u_fifo (
        .clk          (clk),
        .rst          (rst),
        .ent_valid    (ent_valid),
        .ent_index    (ent_index),
        .ent_count    (ent_count),
        .ent_last     (ent_last),
        .buf_pop      (buf_pop),
        .buf_valid    (buf_valid),
        .buf_index    (buf_index),
        .buf_count    (buf_count),
        .buf_last     (buf_last),
        .credit_return(credit_return)
    );

    least_pair_finder #(
        .NUM_SYMBOLS(NUM_SYMBOLS),
        .COUNT_W    (COUNT_W)
    ) u_finder (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .buf_valid   (buf_valid),
        .buf_index   (buf_index),
        .buf_count   (buf_count),
        .buf_last    (buf_last),
        .result_ack  (result_ack),
        .scan_active (scan_active),
        .buf_pop     (buf_pop),
        .busy        (busy),
        .result_valid(result_valid),
        .pair_found  (pair_found),
        .least1      (least1),
        .least2      (least2),
        .pair_sum    (pair_sum)
    );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // Released clear of the edge
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- test/min_search_checker.sv
`timescale 1ns/100ps
`default_nettype none

module min_search_checker #(
    parameter int IDX_W   = 5,
    parameter int COUNT_W = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               result_valid,
    input  logic               pair_found,
    input  logic [IDX_W-1:0]   least1,
    input  logic [IDX_W-1:0]   least2,
    input  logic [COUNT_W-1:0] pair_sum,
    input  logic               exp_found,
    input  logic [IDX_W-1:0]   exp_least1,
    input  logic [IDX_W-1:0]   exp_least2,
    input  logic [COUNT_W-1:0] exp_sum,
    output int                 error_count,
    output int                 result_count
);

    logic result_seen;

    function automatic int field_mismatch(input string what, input logic [31:0] got,
                                          input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at time %0d ns: %s is %h, expected %h", $time, what, got, exp);
            return 1;
        end
        return 0;
    endfunction

    // Outputs are registered, so mid-cycle they are settled
    always @(negedge clk or posedge rst) begin
        int errs;
        if (rst) begin
            result_seen  <= 1'b0;
            error_count  <= 0;
            result_count <= 0;
        end else begin
            result_seen <= result_valid;
            if (result_valid && !result_seen) begin  // New result
                errs = field_mismatch("pair_found", 32'(pair_found), 32'(exp_found));
                errs += field_mismatch("least1", 32'(least1), 32'(exp_least1));
                errs += field_mismatch("least2", 32'(least2), 32'(exp_least2));
                errs += field_mismatch("pair_sum", 32'(pair_sum), 32'(exp_sum));
                error_count  <= error_count + errs;
                result_count <= result_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/min_search_properties.sv
`timescale 1ns/100ps
`default_nettype none

module min_search_properties #(
    parameter int FIFO_DEPTH = huff_pkg::FIFO_DEPTH_DEF,
    parameter int CREDIT_W   = $clog2(FIFO_DEPTH + 1)
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  ent_valid,
    input logic [CREDIT_W-1:0]   credit_cnt,
    input huff_pkg::scan_state_t scan_state,
    input huff_pkg::find_state_t find_state,
    input logic                  result_valid,
    input logic                  result_ack,
    input logic                  busy
);
    import huff_pkg::*;

    int fail_count = 0;

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= FIFO_DEPTH)
        else begin
            $error("credit count above the buffer depth");
            fail_count++;
        end

    // An entry on the wire still holds the credit it spent
    send_needs_credit: assert property (@(posedge clk) disable iff (rst)
        ent_valid |-> credit_cnt != '0)
        else begin
            $error("entry sent with no credit");
            fail_count++;
        end

    result_held: assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ack |=> result_valid)
        else begin
            $error("result dropped before result_ack");
            fail_count++;
        end

    result_busy: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> busy)
        else begin
            $error("result shown while not busy");
            fail_count++;
        end

    // No new scan may begin until the result is acknowledged
    report_scan_idle: assert property (@(posedge clk) disable iff (rst)
        find_state == FIND_REPORT |-> scan_state == SCAN_IDLE)
        else begin
            $error("scan running while the result is shown");
            fail_count++;
        end

endmodule

bind huff_min_search min_search_properties #(
    .FIFO_DEPTH(FIFO_DEPTH)
) u_properties (
    .clk         (clk),
    .rst         (rst),
    .ent_valid   (ent_valid),
    .credit_cnt  (u_scanner.credit_cnt),
    .scan_state  (u_scanner.scan_state),
    .find_state  (u_finder.find_state),
    .result_valid(result_valid),
    .result_ack  (result_ack),
    .busy        (busy)
);

`default_nettype wire

//--- test/tb_huff_min_search.sv
`timescale 1ns/100ps
`default_nettype none

module tb_huff_min_search;
    import huff_pkg::*;

    localparam int NUM_SYMBOLS = 16;
    localparam int COUNT_W     = 16;
    localparam int FIFO_DEPTH  = 4;
    localparam int IDX_W       = index_w(NUM_SYMBOLS);
    localparam int DRIVE_DELAY = 2;
    localparam int TIMEOUT     = 5000;  // Cycles, a full scan under heavy hold fits easily

    logic               clk;
    logic               rst;
    logic               start;
    logic               wr_en;
    logic [IDX_W-1:0]   wr_addr;
    logic [COUNT_W-1:0] wr_count;
    logic               hold;
    logic               result_ack;
    logic               busy;
    logic               result_valid;
    logic               pair_found;
    logic [IDX_W-1:0]   least1;
    logic [IDX_W-1:0]   least2;
    logic [COUNT_W-1:0] pair_sum;
    logic               exp_found;
    logic [IDX_W-1:0]   exp_least1;
    logic [IDX_W-1:0]   exp_least2;
    logic [COUNT_W-1:0] exp_sum;
    logic [31:0]        hold_mask;
    integer             hold_seed;
    int                 error_count;
    int                 result_count;
    int                 scan_count;
    int                 other_errors;
    bit                 timed_out;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) u_clock_gen (.clk(clk), .rst(rst));

    huff_min_search #(
        .NUM_SYMBOLS(NUM_SYMBOLS),
        .COUNT_W    (COUNT_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_count    (wr_count),
        .hold        (hold),
        .result_ack  (result_ack),
        .busy        (busy),
        .result_valid(result_valid),
        .pair_found  (pair_found),
        .least1      (least1),
        .least2      (least2),
        .pair_sum    (pair_sum)
    );

    min_search_checker #(.IDX_W(IDX_W), .COUNT_W(COUNT_W)) u_checker (
        .clk         (clk),
        .rst         (rst),
        .result_valid(result_valid),
        .pair_found  (pair_found),
        .least1      (least1),
        .least2      (least2),
        .pair_sum    (pair_sum),
        .exp_found   (exp_found),
        .exp_least1  (exp_least1),
        .exp_least2  (exp_least2),
        .exp_sum     (exp_sum),
        .error_count (error_count),
        .result_count(result_count)
    );

    // Back-pressure, any masked random bit set raises hold
    always @(posedge clk) begin
        #DRIVE_DELAY;
        hold = |($random(hold_seed) & hold_mask);
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic write_entry(input logic [IDX_W-1:0] addr, input logic [COUNT_W-1:0] count);
        next_cycle();
        wr_en    = 1'b1;
        wr_addr  = addr;
        wr_count = count;
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic clear_table();
        for (int i = 0; i < 2 * NUM_SYMBOLS; i++) begin
            write_entry(IDX_W'(i), '0);
        end
    endtask

    task automatic pulse_start();
        next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic wait_busy_low(input string where);
        int cycles;
        cycles = 0;
        while (busy && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (busy) begin
            $display("Timeout: busy stayed high %s", where);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        while (!result_valid && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!result_valid) begin
            $display("Timeout: no result appeared after start");
            timed_out = 1'b1;
        end
    endtask

    task automatic run_scan(input logic found, input logic [IDX_W-1:0] l1,
                            input logic [IDX_W-1:0] l2, input logic [COUNT_W-1:0] sum);
        exp_found  = found;
        exp_least1 = l1;
        exp_least2 = l2;
        exp_sum    = sum;
        wait_busy_low("before start");
        if (!timed_out) begin
            pulse_start();
            wait_result();
        end
        if (!timed_out) begin
            pulse_start();  // Lands while busy, with the scanner idle and the result shown
            result_ack = 1'b1;
            next_cycle();
            result_ack = 1'b0;
            wait_busy_low("after result_ack");
        end
        scan_count++;
        if (!timed_out && result_count != scan_count) begin
            $display("Result count wrong: %0d scans started but %0d results seen",
                     scan_count, result_count);
            other_errors++;
        end
    endtask

    initial begin
        int              fd;
        int              code;
        int              cycles;
        int              assert_fails;
        byte             cmd;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        logic [31:0]     d;
        logic [8*80-1:0] rest;
        start        = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_count     = '0;
        hold         = 1'b0;
        result_ack   = 1'b0;
        exp_found    = 1'b0;
        exp_least1   = '0;
        exp_least2   = '0;
        exp_sum      = '0;
        hold_mask    = '0;
        hold_seed    = 32'hf9d3;
        scan_count   = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        cycles       = 0;
        while (rst !== 1'b0 && cycles < 20) begin
            next_cycle();
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end
        fd = $fopen("test/min_search_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stim file test/min_search_stim.txt");
            other_errors++;
        end else begin
            code = $fscanf(fd, " %c", cmd);
            while (code == 1 && !timed_out) begin
                case (cmd)
                    "#": code = $fgets(rest, fd);  // Comment line
                    "C": clear_table();
                    "W": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        write_entry(a[IDX_W-1:0], b[COUNT_W-1:0]);
                    end
                    "H": begin
                        code = $fscanf(fd, "%h", a);
                        hold_mask = a & 32'hf;
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                        run_scan(a[0], b[IDX_W-1:0], c[IDX_W-1:0], d[COUNT_W-1:0]);
                    end
                    default: begin
                        $display("Unknown record '%c' in the stim file", cmd);
                        other_errors++;
                    end
                endcase
                code = $fscanf(fd, " %c", cmd);
            end
            $fclose(fd);
        end
        assert_fails = DUT.u_properties.fail_count;
        $display("Scans %0d, results %0d, errors %0d value %0d other %0d assert %0d timeout",
                 scan_count, result_count, error_count, other_errors, assert_fails, timed_out);
        if (error_count == 0 && other_errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/huff_pkg.sv
design/freq_table_scanner.sv
design/entry_fifo.sv
design/least_pair_finder.sv
design/huff_min_search.sv
test/tb_clock_gen.sv
test/min_search_checker.sv
test/min_search_properties.sv
test/tb_huff_min_search.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_huff_min_search
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  OBJ_DIR=$(OBJ_DIR) VFLAGS='$(VFLAGS)'"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/min_search_stim.txt
# Records: W addr count | C | H mask | S found least1 least2 sum
# All fields hex; H mask gates four random hold bits, 0 means no hold
H 0
C
W 03 0040
W 07 0015
W 0a 0009
W 0c 0100
W 0e 0030
S 1 0a 07 001e
H f
S 1 0a 07 001e
H 0
C
W 02 0005
W 05 0005
W 09 0005
W 0b 0008
S 1 02 05 000a
W 13 0003
W 1f 0004
S 1 13 1f 0007
H f
S 1 13 1f 0007
H 3
C
W 06 0022
S 0 00 00 0000
C
S 0 00 00 0000
